// ==== include/lsu_settings.svh ====
/*
 * Load/store unit settings
 * Widths and sizes shared by the package, the RTL and the testbench.
 */

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define LSU_XLEN 32
// transaction id width
`define LSU_ID_BITS 4
// data RAM depth in 32-bit words
`define LSU_RAM_WORDS 64
// issue buffer entries
`define LSU_BUF_DEPTH 2

`endif

// ==== src/lsu_pkg.sv ====
/*
 * Load/store unit package
 * Opcode and exception cause encodings, the request, control, exception
 * and result structs, and the load/store class helper.
 */

`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // RISC-V mcause encodings
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    LD_ACCESS_FAULT    = 4'd5,
    ST_ADDR_MISALIGNED = 4'd6,
    ST_ACCESS_FAULT    = 4'd7
  } lsu_cause_e;

  typedef struct packed {
    logic                 valid;
    lsu_cause_e           cause;
    logic [`LSU_XLEN-1:0] tval;
  } lsu_exception_t;

  typedef struct packed {
    lsu_op_e                 op;
    logic [`LSU_XLEN-1:0]    operand_a;
    logic [`LSU_XLEN-1:0]    imm;
    logic [`LSU_XLEN-1:0]    operand_b;
    logic [`LSU_ID_BITS-1:0] trans_id;
  } lsu_req_t;

  // one buffered access after address generation
  typedef struct packed {
    logic [`LSU_XLEN-1:0]     vaddr;
    logic [`LSU_XLEN-1:0]     wdata;
    logic [`LSU_XLEN/8-1:0]   be;
    lsu_op_e                  op;
    logic [`LSU_ID_BITS-1:0]  trans_id;
    lsu_exception_t           ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic [`LSU_ID_BITS-1:0] trans_id;
    logic [`LSU_XLEN-1:0]    result;
    lsu_exception_t          ex;
  } lsu_result_t;

  function automatic logic lsu_is_store(lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

endpackage

`default_nettype wire

// ==== src/lsu_agu.sv ====
/*
 * Address generation
 * Forms the access address from base plus immediate, derives the byte
 * enables, moves store data into its byte lanes and flags misaligned
 * or out-of-range accesses.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_agu
  import lsu_pkg::*;
(
  input  lsu_req_t  req_i,
  output lsu_ctrl_t ctrl_o
);

  localparam logic [`LSU_XLEN-1:0] RAM_BYTES = `LSU_XLEN'(`LSU_RAM_WORDS * 4);

  logic [`LSU_XLEN-1:0] vaddr;
  logic                 is_half;
  logic                 is_word;
  logic                 is_store;
  logic                 misaligned;
  logic                 out_of_range;

  assign vaddr    = req_i.operand_a + req_i.imm;
  assign is_half  = (req_i.op == LH) || (req_i.op == LHU) || (req_i.op == SH);
  assign is_word  = (req_i.op == LW) || (req_i.op == SW);
  assign is_store = lsu_is_store(req_i.op);

  // --------------------
  // exception detection
  // --------------------
  assign misaligned   = (is_half && vaddr[0]) || (is_word && (vaddr[1:0] != 2'b00));
  assign out_of_range = (vaddr >= RAM_BYTES);

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.vaddr    = vaddr;
    ctrl_o.op       = req_i.op;
    ctrl_o.trans_id = req_i.trans_id;

    // byte enables by size and low address bits
    if (is_word) begin
      ctrl_o.be = 4'b1111;
    end else if (is_half) begin
      ctrl_o.be = 4'b0011 << vaddr[1:0];
    end else begin
      ctrl_o.be = 4'b0001 << vaddr[1:0];
    end

    // store data moves up to the addressed lane
    ctrl_o.wdata = req_i.operand_b << {vaddr[1:0], 3'b000};

    // misalignment wins over the access fault
    if (misaligned) begin
      ctrl_o.ex.valid = 1'b1;
      ctrl_o.ex.cause = is_store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
      ctrl_o.ex.tval  = vaddr;
    end else if (out_of_range) begin
      ctrl_o.ex.valid = 1'b1;
      ctrl_o.ex.cause = is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
      ctrl_o.ex.tval  = vaddr;
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_issue_buffer.sv ====
/*
 * Issue buffer
 * In-order circular buffer of control words between the AGU and the
 * load and store units. Back-pressures the issue port when full.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_issue_buffer
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  lsu_ctrl_t ctrl_i,
  output logic      ready_o,
  output lsu_ctrl_t head_o,
  output logic      head_valid_o,
  input  logic      ld_pop_i,
  input  logic      st_pop_i
);

  localparam int unsigned PW = (`LSU_BUF_DEPTH > 1) ? $clog2(`LSU_BUF_DEPTH) : 1;
  localparam int unsigned CW = $clog2(`LSU_BUF_DEPTH + 1);

  lsu_ctrl_t         entries_q [`LSU_BUF_DEPTH];
  logic [PW-1:0]     rd_ptr_q;
  logic [PW-1:0]     wr_ptr_q;
  logic [CW-1:0]     count_q;
  logic              push;
  logic              pop;

  function automatic logic [PW-1:0] next_ptr(logic [PW-1:0] ptr);
    return (ptr == PW'(`LSU_BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o      = (count_q < CW'(`LSU_BUF_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_o       = entries_q[rd_ptr_q];

  assign push = push_i && ready_o;
  assign pop  = (ld_pop_i || st_pop_i) && head_valid_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      entries_q[wr_ptr_q] <= ctrl_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      // occupancy holds on push with pop
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_load_unit.sv ====
/*
 * Load unit
 * Takes a load from the buffer head, reads the data RAM and returns
 * the aligned, extended value one cycle later. Holds back while a
 * pending store targets the same word.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_load_unit
  import lsu_pkg::*;
#(
  parameter int unsigned AW = $clog2(`LSU_RAM_WORDS)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_ctrl_t            head_i,
  input  logic                 head_valid_i,
  output logic                 pop_o,
  output logic [AW-1:0]        chk_word_o,
  input  logic                 addr_match_i,
  output logic                 ram_rd_en_o,
  output logic [AW-1:0]        ram_rd_addr_o,
  input  logic [`LSU_XLEN-1:0] ram_rd_data_i,
  output logic                 valid_o,
  output lsu_result_t          result_o
);

  logic                    is_load;
  logic                    valid_q;
  lsu_op_e                 op_q;
  logic [1:0]              off_q;
  logic [`LSU_ID_BITS-1:0] id_q;
  lsu_exception_t          ex_q;
  logic [`LSU_XLEN-1:0]    lane;
  logic [`LSU_XLEN-1:0]    data_ext;

  // --------------------
  // issue side
  // --------------------
  assign is_load    = head_valid_i && !lsu_is_store(head_i.op);
  assign chk_word_o = head_i.vaddr[AW+1:2];

  // wait for the pending store to the same word to commit
  assign pop_o         = is_load && !addr_match_i;
  assign ram_rd_en_o   = pop_o && !head_i.ex.valid;
  assign ram_rd_addr_o = chk_word_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pop_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      op_q  <= head_i.op;
      off_q <= head_i.vaddr[1:0];
      id_q  <= head_i.trans_id;
      ex_q  <= head_i.ex;
    end
  end

  // --------------------
  // writeback side
  // --------------------
  assign lane = ram_rd_data_i >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      data_ext = {{(`LSU_XLEN-8){lane[7]}}, lane[7:0]};
      LBU:     data_ext = {{(`LSU_XLEN-8){1'b0}}, lane[7:0]};
      LH:      data_ext = {{(`LSU_XLEN-16){lane[15]}}, lane[15:0]};
      LHU:     data_ext = {{(`LSU_XLEN-16){1'b0}}, lane[15:0]};
      default: data_ext = ram_rd_data_i;
    endcase
  end

  assign valid_o           = valid_q;
  assign result_o.trans_id = id_q;
  assign result_o.result   = ex_q.valid ? '0 : data_ext;
  assign result_o.ex       = ex_q;

endmodule

`default_nettype wire

// ==== src/lsu_store_unit.sv ====
/*
 * Store unit
 * Reports a store one cycle after taking it from the buffer, keeps it
 * pending and writes the data RAM when the commit arrives.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_store_unit
  import lsu_pkg::*;
#(
  parameter int unsigned AW = $clog2(`LSU_RAM_WORDS)
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lsu_ctrl_t              head_i,
  input  logic                   head_valid_i,
  output logic                   pop_o,
  input  logic [AW-1:0]          chk_word_i,
  output logic                   addr_match_o,
  input  logic                   commit_i,
  output logic                   commit_ready_o,
  output logic                   ram_we_o,
  output logic [AW-1:0]          ram_wr_addr_o,
  output logic [`LSU_XLEN-1:0]   ram_wr_data_o,
  output logic [`LSU_XLEN/8-1:0] ram_be_o,
  output logic                   valid_o,
  output lsu_result_t            result_o
);

  logic                    rep_valid_q;
  logic [`LSU_ID_BITS-1:0] rep_id_q;
  lsu_exception_t          rep_ex_q;
  logic                    pend_q;
  logic [AW-1:0]           pend_word_q;
  logic [`LSU_XLEN-1:0]    pend_data_q;
  logic [`LSU_XLEN/8-1:0]  pend_be_q;

  // one pending slot, so the next store waits for the commit
  assign pop_o = head_valid_i && lsu_is_store(head_i.op) && !pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rep_valid_q <= 1'b0;
      pend_q      <= 1'b0;
    end else begin
      rep_valid_q <= pop_o;
      if (pop_o && !head_i.ex.valid) begin
        pend_q <= 1'b1;
      end else if (commit_i && pend_q) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      rep_id_q    <= head_i.trans_id;
      rep_ex_q    <= head_i.ex;
      pend_word_q <= head_i.vaddr[AW+1:2];
      pend_data_q <= head_i.wdata;
      pend_be_q   <= head_i.be;
    end
  end

  assign addr_match_o   = pend_q && (pend_word_q == chk_word_i);
  assign commit_ready_o = pend_q;

  assign ram_we_o      = commit_i && pend_q;
  assign ram_wr_addr_o = pend_word_q;
  assign ram_wr_data_o = pend_data_q;
  assign ram_be_o      = pend_be_q;

  assign valid_o           = rep_valid_q;
  assign result_o.trans_id = rep_id_q;
  assign result_o.result   = '0;
  assign result_o.ex       = rep_ex_q;

endmodule

`default_nettype wire

// ==== src/lsu_data_ram.sv ====
/*
 * Data RAM
 * Word array with a byte-enabled write port and a registered read port.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_data_ram #(
  parameter int unsigned AW = $clog2(`LSU_RAM_WORDS)
) (
  input  logic                   clk_i,
  input  logic                   rd_en_i,
  input  logic [AW-1:0]          rd_addr_i,
  output logic [`LSU_XLEN-1:0]   rd_data_o,
  input  logic                   we_i,
  input  logic [AW-1:0]          wr_addr_i,
  input  logic [`LSU_XLEN-1:0]   wr_data_i,
  input  logic [`LSU_XLEN/8-1:0] be_i
);

  logic [`LSU_XLEN-1:0] mem_q [`LSU_RAM_WORDS];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (be_i[b]) begin
          mem_q[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
        end
      end
    end
    // read data held until the next read
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
/*
 * Load/store unit top level
 * Connects the AGU, the issue buffer, the load and store units and the
 * internal data RAM.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  lsu_req_t    req_i,
  output logic        req_ready_o,
  output logic        load_valid_o,
  output lsu_result_t load_result_o,
  output logic        store_valid_o,
  output lsu_result_t store_result_o,
  input  logic        commit_i,
  output logic        commit_ready_o
);

  localparam int unsigned AW = $clog2(`LSU_RAM_WORDS);

  lsu_ctrl_t              ctrl;
  lsu_ctrl_t              head;
  logic                   head_valid;
  logic                   ld_pop;
  logic                   st_pop;
  logic [AW-1:0]          chk_word;
  logic                   addr_match;
  logic                   ram_rd_en;
  logic [AW-1:0]          ram_rd_addr;
  logic [`LSU_XLEN-1:0]   ram_rd_data;
  logic                   ram_we;
  logic [AW-1:0]          ram_wr_addr;
  logic [`LSU_XLEN-1:0]   ram_wr_data;
  logic [`LSU_XLEN/8-1:0] ram_be;

  lsu_agu i_agu (
    .req_i  (req_i),
    .ctrl_o (ctrl)
  );

  lsu_issue_buffer i_issue_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (req_valid_i),
    .ctrl_i       (ctrl),
    .ready_o      (req_ready_o),
    .head_o       (head),
    .head_valid_o (head_valid),
    .ld_pop_i     (ld_pop),
    .st_pop_i     (st_pop)
  );

  lsu_load_unit #(.AW(AW)) i_load_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_i        (head),
    .head_valid_i  (head_valid),
    .pop_o         (ld_pop),
    .chk_word_o    (chk_word),
    .addr_match_i  (addr_match),
    .ram_rd_en_o   (ram_rd_en),
    .ram_rd_addr_o (ram_rd_addr),
    .ram_rd_data_i (ram_rd_data),
    .valid_o       (load_valid_o),
    .result_o      (load_result_o)
  );

  lsu_store_unit #(.AW(AW)) i_store_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_i         (head),
    .head_valid_i   (head_valid),
    .pop_o          (st_pop),
    .chk_word_i     (chk_word),
    .addr_match_o   (addr_match),
    .commit_i       (commit_i),
    .commit_ready_o (commit_ready_o),
    .ram_we_o       (ram_we),
    .ram_wr_addr_o  (ram_wr_addr),
    .ram_wr_data_o  (ram_wr_data),
    .ram_be_o       (ram_be),
    .valid_o        (store_valid_o),
    .result_o       (store_result_o)
  );

  lsu_data_ram #(.AW(AW)) i_data_ram (
    .clk_i     (clk_i),
    .rd_en_i   (ram_rd_en),
    .rd_addr_i (ram_rd_addr),
    .rd_data_o (ram_rd_data),
    .we_i      (ram_we),
    .wr_addr_i (ram_wr_addr),
    .wr_data_i (ram_wr_data),
    .be_i      (ram_be)
  );

endmodule

`default_nettype wire

// ==== tb/lsu_properties.sv ====
/*
 * Load/store unit properties
 * Concurrent checks on the issue handshake, the commit handshake,
 * reset values and exception causes, bound to the top level.
 */

`default_nettype none

`include "lsu_settings.svh"

module lsu_properties
  import lsu_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        req_valid_i,
  input lsu_req_t    req_i,
  input logic        req_ready_i,
  input logic        load_valid_i,
  input lsu_result_t load_result_i,
  input logic        store_valid_i,
  input lsu_result_t store_result_i,
  input logic        commit_i,
  input logic        commit_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // request held while stalled
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && !req_ready_i) |=> (req_valid_i && $stable(req_i)))
    else begin
      $error("request changed while stalled");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_ready_i)
    else begin
      $error("commit without a pending store");
      fail_count++;
    end

  // values seen during reset
  assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!load_valid_i && !store_valid_i && !commit_ready_i && req_ready_i))
    else begin
      $error("outputs not idle during reset");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (load_valid_i && load_result_i.ex.valid) |->
      (load_result_i.ex.cause == LD_ADDR_MISALIGNED ||
       load_result_i.ex.cause == LD_ACCESS_FAULT))
    else begin
      $error("load result with a store cause");
      fail_count++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (store_valid_i && store_result_i.ex.valid) |->
      (store_result_i.ex.cause == ST_ADDR_MISALIGNED ||
       store_result_i.ex.cause == ST_ACCESS_FAULT))
    else begin
      $error("store result with a load cause");
      fail_count++;
    end

endmodule

bind lsu_top lsu_properties lsu_properties_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .req_valid_i    (req_valid_i),
  .req_i          (req_i),
  .req_ready_i    (req_ready_o),
  .load_valid_i   (load_valid_o),
  .load_result_i  (load_result_o),
  .store_valid_i  (store_valid_o),
  .store_result_i (store_result_o),
  .commit_i       (commit_i),
  .commit_ready_i (commit_ready_o)
);

`default_nettype wire

// ==== tb/tb_lsu.sv ====
/*
 * Load/store unit testbench
 * Issues the requests of the cases file, commits stores after a random
 * delay and checks every load and store result in issue order.
 */

`default_nettype none

`include "lsu_settings.svh"

module tb_lsu
  import lsu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_CASES    = 37;
  localparam int unsigned CASE_WORDS = 8;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  lsu_req_t    req;
  logic        req_ready;
  logic        load_valid;
  lsu_result_t load_result;
  logic        store_valid;
  lsu_result_t store_result;
  logic        commit;
  logic        commit_ready;

  logic [`LSU_XLEN-1:0] case_words [N_CASES * CASE_WORDS];
  lsu_result_t          load_q [$];
  lsu_result_t          store_q [$];
  int                   seed = 68;
  logic                 stall_seen;

  lsu_top lsu_top_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .load_valid_o   (load_valid),
    .load_result_o  (load_result),
    .store_valid_o  (store_valid),
    .store_result_o (store_result),
    .commit_i       (commit),
    .commit_ready_o (commit_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_load(input lsu_result_t got, input lsu_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR load_result_o got %h exp %h", got, exp));
    end
  endtask

  task automatic check_store(input lsu_result_t got, input lsu_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR store_result_o got %h exp %h", got, exp));
    end
  endtask

  // --------------------
  // case decoding
  // --------------------
  function automatic lsu_req_t case_req(int unsigned idx);
    lsu_req_t    r;
    int unsigned base;
    base        = idx * CASE_WORDS;
    r.op        = lsu_op_e'(case_words[base][2:0]);
    r.operand_a = case_words[base + 1];
    r.imm       = case_words[base + 2];
    r.operand_b = case_words[base + 3];
    r.trans_id  = case_words[base + 4][`LSU_ID_BITS-1:0];
    return r;
  endfunction

  function automatic lsu_result_t case_exp(int unsigned idx);
    lsu_result_t          e;
    int unsigned          base;
    logic [`LSU_XLEN-1:0] addr;
    base       = idx * CASE_WORDS;
    addr       = case_words[base + 1] + case_words[base + 2];
    e.trans_id = case_words[base + 4][`LSU_ID_BITS-1:0];
    e.result   = case_words[base + 5];
    e.ex.valid = case_words[base + 6][0];
    e.ex.cause = lsu_cause_e'(case_words[base + 7][3:0]);
    // tval is the faulting address, zero otherwise
    e.ex.tval  = e.ex.valid ? addr : '0;
    return e;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  initial begin : stimulus
    lsu_req_t    r;
    lsu_result_t e;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req        = '0;
    stall_seen = 1'b0;
    $readmemh("tb/lsu_cases.txt", case_words);
    if ($isunknown(case_words[N_CASES * CASE_WORDS - 1])) begin
      abort_run("cases file missing or shorter than expected");
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < N_CASES; i++) begin
      r = case_req(i);
      e = case_exp(i);
      if (r.op == SB || r.op == SH || r.op == SW) begin
        store_q.push_back(e);
      end else begin
        load_q.push_back(e);
      end
      req_valid <= 1'b1;
      req       <= r;
      // hold until the buffer takes it
      do @(posedge clk); while (!req_ready);
    end
    req_valid <= 1'b0;
    while (load_q.size() != 0 || store_q.size() != 0) @(posedge clk);
    while (commit_ready) @(posedge clk);
    repeat (2) @(posedge clk);
    if (lsu_top_i.lsu_properties_i.fail_count != 0) begin
      abort_run("assertion failures were reported");
    end else if (!stall_seen) begin
      abort_run("req_ready_o never dropped while commits were delayed");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // commit a pending store 0 to 3 cycles after it shows up
  initial begin : commit_driver
    int delay;
    commit = 1'b0;
    forever begin
      @(posedge clk);
      if (commit_ready) begin
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk);
        commit <= 1'b1;
        @(posedge clk);
        commit <= 1'b0;
      end
    end
  end

  // results sampled mid-cycle
  always @(negedge clk) begin
    if (lsu_top_i.lsu_properties_i.fail_count != 0) begin
      abort_run("a bound assertion failed");
    end
    // issue port back-pressure seen at least once
    if (rst_n && req_valid && !req_ready) begin
      stall_seen = 1'b1;
    end
    if (rst_n && load_valid) begin
      if (load_q.size() == 0) begin
        abort_run("load result arrived with no load outstanding");
      end else begin
        check_load(load_result, load_q.pop_front());
      end
    end
    if (rst_n && store_valid) begin
      if (store_q.size() == 0) begin
        abort_run("store result arrived with no store outstanding");
      end else begin
        check_store(store_result, store_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    repeat (N_CASES * 20) @(posedge clk);
    abort_run("timeout: not all results arrived within the cycle budget");
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/lsu_pkg.sv
src/lsu_agu.sv
src/lsu_issue_buffer.sv
src/lsu_load_unit.sv
src/lsu_store_unit.sv
src/lsu_data_ram.sv
src/lsu_top.sv
tb/lsu_properties.sv
tb/tb_lsu.sv

// ==== Makefile ====
# Verilator lint and simulation of the load/store unit

TOP := tb_lsu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

# pass or fail is read back from the log
sim:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/lsu_cases.txt ====
// columns (hex): op base imm store_data id exp_result exc_valid exc_cause
// op: 0 LB, 1 LBU, 2 LH, 3 LHU, 4 LW, 5 SB, 6 SH, 7 SW
// word store, then loads of every size and offset
7 00000010 00000000 8badf00d 1 00000000 0 0
4 00000010 00000000 00000000 2 8badf00d 0 0
4 00000014 fffffffc 00000000 3 8badf00d 0 0
2 00000010 00000000 00000000 4 fffff00d 0 0
2 00000010 00000002 00000000 5 ffff8bad 0 0
3 00000010 00000000 00000000 6 0000f00d 0 0
3 00000010 00000002 00000000 7 00008bad 0 0
0 00000010 00000000 00000000 8 0000000d 0 0
0 00000010 00000001 00000000 9 fffffff0 0 0
0 00000010 00000002 00000000 a ffffffad 0 0
0 00000010 00000003 00000000 b ffffff8b 0 0
1 00000010 00000000 00000000 c 0000000d 0 0
1 00000010 00000001 00000000 d 000000f0 0 0
1 00000010 00000002 00000000 e 000000ad 0 0
1 00000010 00000003 00000000 f 0000008b 0 0
// sub-word stores merge into the word
7 00000020 00000000 11223344 0 00000000 0 0
5 00000020 00000001 123456aa 1 00000000 0 0
6 00000020 00000002 abcdbeef 2 00000000 0 0
4 00000020 00000000 00000000 3 beefaa44 0 0
5 00000023 00000000 00000077 4 00000000 0 0
4 00000020 00000000 00000000 5 77efaa44 0 0
// misaligned accesses, the word stays unchanged
2 00000010 00000001 00000000 6 00000000 1 4
4 00000010 00000002 00000000 7 00000000 1 4
6 00000020 00000001 ffffffff 8 00000000 1 6
7 00000020 00000003 ffffffff 9 00000000 1 6
4 00000020 00000000 00000000 a 77efaa44 0 0
// access faults and the last byte of the RAM
4 00000100 00000000 00000000 b 00000000 1 5
7 000000fc 00000004 00000000 c 00000000 1 7
0 00000000 000001ff 00000000 d 00000000 1 5
4 00000101 00000000 00000000 e 00000000 1 4
5 000000ff 00000000 0000005a f 00000000 0 0
1 000000ff 00000000 00000000 0 0000005a 0 0
// store burst against delayed commits
7 00000040 00000000 a0a0a0a0 1 00000000 0 0
7 00000044 00000000 b1b1b1b1 2 00000000 0 0
7 00000048 00000000 c2c2c2c2 3 00000000 0 0
4 00000044 00000000 00000000 4 b1b1b1b1 0 0
4 00000040 00000000 00000000 5 a0a0a0a0 0 0
